//--- all.f
+incdir+tests
common/apb_pkg.sv
common/apb_if.sv
apb_splitter/onehot_mux.sv
apb_splitter/apb_splitter.sv
hw/apb_cmd_bridge.sv
hw/apb_regfile.sv
hw/apb_subsys_top.sv
tests/tb_apb_subsys.sv

//--- apb_splitter/apb_splitter.sv
`timescale 1ns/100ps

module apb_splitter #(
	parameter int N_SLAVES = apb_pkg::N_SLAVES,
	parameter logic [N_SLAVES*apb_pkg::W_ADDR-1:0] ADDR_MAP  = apb_pkg::ADDR_MAP,
	parameter logic [N_SLAVES*apb_pkg::W_ADDR-1:0] ADDR_MASK = apb_pkg::ADDR_MASK
) (
	apb_if.slave  up,
	apb_if.master down [N_SLAVES]
);

localparam int W_ADDR = apb_pkg::W_ADDR;
localparam int W_DATA = apb_pkg::W_DATA;

logic [N_SLAVES-1:0]        sel;
logic [N_SLAVES-1:0]        pready_v;
logic [N_SLAVES-1:0]        pslverr_v;
logic [N_SLAVES*W_DATA-1:0] prdata_v;
logic                       no_match;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	for (int i = 0; i < N_SLAVES; i++) begin
		sel[i] = (up.paddr & ADDR_MASK[i*W_ADDR +: W_ADDR]) == ADDR_MAP[i*W_ADDR +: W_ADDR];
	end
end

assign no_match = ~|sel;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fan out and collect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

for (genvar g = 0; g < N_SLAVES; g++) begin : g_port
	assign down[g].paddr   = up.paddr;
	assign down[g].pwdata  = up.pwdata;
	assign down[g].psel    = sel[g] & up.psel;
	assign down[g].penable = sel[g] & up.penable;
	assign down[g].pwrite  = sel[g] & up.pwrite;

	assign pready_v[g]                   = down[g].pready;
	assign pslverr_v[g]                  = down[g].pslverr;
	assign prdata_v[g*W_DATA +: W_DATA]  = down[g].prdata;
end

// unmapped addresses finish in the first access cycle with an error
assign up.pready  = no_match | (|(sel & pready_v));
assign up.pslverr = no_match | (|(sel & pslverr_v));

onehot_mux #(
	.N_INPUTS(N_SLAVES),
	.W_INPUT(W_DATA)
) prdata_mux_i (
	.in(prdata_v),
	.sel(sel),
	.out(up.prdata) // zero when nothing is selected
);

// overlapping map entries would merge two slaves' responses
a_sel_onehot: assert property (
	@(posedge up.clk)
	up.psel |-> $onehot0(sel)
);

endmodule

//--- apb_splitter/onehot_mux.sv
`timescale 1ns/100ps

module onehot_mux #(
	parameter int N_INPUTS = 2,
	parameter int W_INPUT  = 32
) (
	input  logic [N_INPUTS*W_INPUT-1:0] in,
	input  logic [N_INPUTS-1:0]         sel,
	output logic [W_INPUT-1:0]          out
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// and-or select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// no priority logic, the caller guarantees at most one bit of sel is set
always_comb begin
	out = '0;
	for (int i = 0; i < N_INPUTS; i++) begin
		out = out | (in[i*W_INPUT +: W_INPUT] & {W_INPUT{sel[i]}});
	end
end

endmodule

//--- common/apb_if.sv
`timescale 1ns/100ps

// one APB link, clk is the bus clock that checkers sample on
interface apb_if (
	input logic clk
);

	apb_pkg::addr_t paddr;
	logic           psel;
	logic           penable;
	logic           pwrite;
	apb_pkg::data_t pwdata;
	logic           pready;
	apb_pkg::data_t prdata;
	logic           pslverr;

	modport master (
		input  clk,
		output paddr,
		output psel,
		output penable,
		output pwrite,
		output pwdata,
		input  pready,
		input  prdata,
		input  pslverr
	);

	modport slave (
		input  clk,
		input  paddr,
		input  psel,
		input  penable,
		input  pwrite,
		input  pwdata,
		output pready,
		output prdata,
		output pslverr
	);

endinterface

//--- common/apb_pkg.sv
package apb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus widths and types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int W_ADDR = 16;
	localparam int W_DATA = 32;

	typedef logic [W_ADDR-1:0] addr_t; // byte address
	typedef logic [W_DATA-1:0] data_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int N_SLAVES = 2;

	// one W_ADDR field per slave, slave 0 in the low field
	localparam logic [N_SLAVES*W_ADDR-1:0] ADDR_MAP  = 32'h0000_4000;
	localparam logic [N_SLAVES*W_ADDR-1:0] ADDR_MASK = 32'hc000_c000;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register files
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int REG_WORDS = 8;

	typedef logic [$clog2(REG_WORDS)-1:0] word_idx_t; // taken from paddr[4:2]

	localparam data_t ID_WORD_0 = 32'h5ec0_0000;
	localparam data_t ID_WORD_1 = 32'h5ec0_0001;

	// command bridge sequencing
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS,
		DONE
	} bridge_state_t;

endpackage

//--- hw/apb_cmd_bridge.sv
`timescale 1ns/100ps

module apb_cmd_bridge (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           cmd_req,
	input  logic           cmd_write,
	input  apb_pkg::addr_t cmd_addr,
	input  apb_pkg::data_t cmd_wdata,
	output logic           cmd_ack,
	output apb_pkg::data_t cmd_rdata,
	output logic           cmd_err,
	apb_if.master          apb
);

apb_pkg::bridge_state_t state_q;
apb_pkg::bridge_state_t state_d;

apb_pkg::addr_t addr_q;
apb_pkg::data_t wdata_q;
logic           write_q;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	state_d = state_q;
	case (state_q)
		apb_pkg::IDLE: begin
			if (cmd_req)
				state_d = apb_pkg::SETUP;
		end
		apb_pkg::SETUP: begin
			state_d = apb_pkg::ACCESS;
		end
		apb_pkg::ACCESS: begin
			if (apb.pready)
				state_d = apb_pkg::DONE; // slow slave just keeps us here
		end
		apb_pkg::DONE: begin
			if (!cmd_req)
				state_d = apb_pkg::IDLE; // four-phase return to zero
		end
		default: begin
			state_d = apb_pkg::IDLE;
		end
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n)
		state_q <= apb_pkg::IDLE;
	else
		state_q <= state_d;
end

// command is held in the bridge so the bus never sees it change mid transfer
always_ff @(posedge clk) begin
	if (state_q == apb_pkg::IDLE && cmd_req) begin
		addr_q  <= cmd_addr;
		wdata_q <= cmd_wdata;
		write_q <= cmd_write;
	end
end

// response is captured on the completing edge
always_ff @(posedge clk) begin
	if (state_q == apb_pkg::ACCESS && apb.pready) begin
		cmd_rdata <= apb.prdata;
		cmd_err   <= apb.pslverr;
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and handshake outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign apb.psel    = (state_q == apb_pkg::SETUP) || (state_q == apb_pkg::ACCESS);
assign apb.penable = (state_q == apb_pkg::ACCESS);
assign apb.paddr   = addr_q;
assign apb.pwdata  = wdata_q;
assign apb.pwrite  = write_q;

assign cmd_ack = (state_q == apb_pkg::DONE);

a_penable_needs_psel: assert property (
	@(posedge clk) disable iff (!rst_n)
	apb.penable |-> apb.psel
);

// address must hold from setup through every wait cycle of access
a_paddr_stable: assert property (
	@(posedge clk) disable iff (!rst_n)
	(apb.psel && apb.penable) |-> $stable(apb.paddr)
);

endmodule

//--- hw/apb_regfile.sv
`timescale 1ns/100ps

module apb_regfile #(
	parameter int             WAIT_STATES = 0,
	parameter apb_pkg::data_t ID_WORD     = apb_pkg::ID_WORD_0
) (
	input logic  clk,
	input logic  rst_n,
	apb_if.slave apb
);

localparam int W_CNT = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

apb_pkg::data_t    regs [1:apb_pkg::REG_WORDS-1]; // word 0 is the ID, no storage
apb_pkg::word_idx_t idx;
logic [W_CNT-1:0]  wait_cnt;
logic              access;
logic              done;
logic              id_write;

assign idx      = apb.paddr[2 +: $bits(apb_pkg::word_idx_t)];
assign access   = apb.psel & apb.penable;
assign done     = access && (wait_cnt == W_CNT'(WAIT_STATES));
assign id_write = apb.pwrite && (idx == '0);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wait states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk) begin
	if (!rst_n)
		wait_cnt <= '0;
	else if (access && !done)
		wait_cnt <= wait_cnt + 1'b1;
	else
		wait_cnt <= '0; // ready for the next transfer
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 1; i < apb_pkg::REG_WORDS; i++) begin
			regs[i] <= '0;
		end
	end else if (done && apb.pwrite && !id_write) begin
		regs[idx] <= apb.pwdata;
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign apb.pready  = done;
assign apb.prdata  = (idx == '0) ? ID_WORD : regs[idx];
assign apb.pslverr = done & id_write; // ID word is read only

// a ready outside access would complete a transfer the master never started
a_pready_in_access: assert property (
	@(posedge clk) disable iff (!rst_n)
	!(apb.psel && apb.penable) |-> !apb.pready
);

endmodule

//--- hw/apb_subsys_top.sv
`timescale 1ns/100ps

module apb_subsys_top #(
	parameter int N_SLAVES = apb_pkg::N_SLAVES,
	parameter logic [N_SLAVES*apb_pkg::W_ADDR-1:0] ADDR_MAP  = apb_pkg::ADDR_MAP,
	parameter logic [N_SLAVES*apb_pkg::W_ADDR-1:0] ADDR_MASK = apb_pkg::ADDR_MASK,
	parameter int             WAIT_STATES_0 = 0,
	parameter int             WAIT_STATES_1 = 0,
	parameter apb_pkg::data_t ID_WORD_0     = apb_pkg::ID_WORD_0,
	parameter apb_pkg::data_t ID_WORD_1     = apb_pkg::ID_WORD_1
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           cmd_req,
	input  logic           cmd_write,
	input  apb_pkg::addr_t cmd_addr,
	input  apb_pkg::data_t cmd_wdata,
	output logic           cmd_ack,
	output apb_pkg::data_t cmd_rdata,
	output logic           cmd_err
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// buses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

apb_if up_bus (.clk(clk));
apb_if dn_bus [N_SLAVES] (.clk(clk));

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

apb_cmd_bridge bridge_i (
	.clk(clk),
	.rst_n(rst_n),
	.cmd_req(cmd_req),
	.cmd_write(cmd_write),
	.cmd_addr(cmd_addr),
	.cmd_wdata(cmd_wdata),
	.cmd_ack(cmd_ack),
	.cmd_rdata(cmd_rdata),
	.cmd_err(cmd_err),
	.apb(up_bus.master)
);

apb_splitter #(
	.N_SLAVES(N_SLAVES),
	.ADDR_MAP(ADDR_MAP),
	.ADDR_MASK(ADDR_MASK)
) splitter_i (
	.up(up_bus.slave),
	.down(dn_bus)
);

// slave 0 sits at 0x4000, slave 1 at 0x0000 with the default map
apb_regfile #(
	.WAIT_STATES(WAIT_STATES_0),
	.ID_WORD(ID_WORD_0)
) regfile_0_i (
	.clk(clk),
	.rst_n(rst_n),
	.apb(dn_bus[0].slave)
);

apb_regfile #(
	.WAIT_STATES(WAIT_STATES_1),
	.ID_WORD(ID_WORD_1)
) regfile_1_i (
	.clk(clk),
	.rst_n(rst_n),
	.apb(dn_bus[1].slave)
);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the APB subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_apb_subsys -f all.f \
	--Mdir obj_dir -o sim_apb_subsys

./obj_dir/sim_apb_subsys | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
	exit 1
fi

//--- tests/tb_apb_vectors.svh
`ifndef TB_APB_VECTORS_SVH
`define TB_APB_VECTORS_SVH

// columns: write, check read data, random slot (-1 uses the literal data columns),
// address, write data, expected read data, expected error

task automatic add_row(input int wr, input int chk_rd, input int slot, input logic [15:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp_rdata, input int exp_err);
	row_t r;
	r.wr        = (wr != 0);
	r.chk_rd    = (chk_rd != 0);
	r.slot      = slot;
	r.addr      = addr;
	r.wdata     = wdata;
	r.exp_rdata = exp_rdata;
	r.exp_err   = (exp_err != 0);
	rows.push_back(r);
endtask

task automatic fill_table();
	// writable words start at zero in both slaves
	add_row(0, 1, -1, 16'h4004, 32'h0, 32'h0, 0);
	add_row(0, 1, -1, 16'h401c, 32'h0, 32'h0, 0);
	add_row(0, 1, -1, 16'h0004, 32'h0, 32'h0, 0);
	add_row(0, 1, -1, 16'h001c, 32'h0, 32'h0, 0);
	// slave 0 has no wait states
	add_row(1, 0, 0, 16'h4004, 32'h0, 32'h0, 0);
	add_row(1, 0, 1, 16'h4008, 32'h0, 32'h0, 0);
	add_row(1, 0, 2, 16'h400c, 32'h0, 32'h0, 0);
	add_row(1, 0, 3, 16'h4010, 32'h0, 32'h0, 0);
	add_row(1, 0, 4, 16'h4014, 32'h0, 32'h0, 0);
	add_row(1, 0, 5, 16'h4018, 32'h0, 32'h0, 0);
	add_row(1, 0, 6, 16'h401c, 32'h0, 32'h0, 0);
	add_row(0, 1, 0, 16'h4004, 32'h0, 32'h0, 0);
	add_row(0, 1, 1, 16'h4008, 32'h0, 32'h0, 0);
	add_row(0, 1, 2, 16'h400c, 32'h0, 32'h0, 0);
	add_row(0, 1, 3, 16'h4010, 32'h0, 32'h0, 0);
	add_row(0, 1, 4, 16'h4014, 32'h0, 32'h0, 0);
	add_row(0, 1, 5, 16'h4018, 32'h0, 32'h0, 0);
	add_row(0, 1, 6, 16'h401c, 32'h0, 32'h0, 0);
	// slave 1 answers after three wait states
	add_row(1, 0, 7, 16'h0004, 32'h0, 32'h0, 0);
	add_row(1, 0, 8, 16'h0008, 32'h0, 32'h0, 0);
	add_row(1, 0, 9, 16'h000c, 32'h0, 32'h0, 0);
	add_row(1, 0, 10, 16'h0010, 32'h0, 32'h0, 0);
	add_row(1, 0, 11, 16'h0014, 32'h0, 32'h0, 0);
	add_row(1, 0, 12, 16'h0018, 32'h0, 32'h0, 0);
	add_row(1, 0, 13, 16'h001c, 32'h0, 32'h0, 0);
	add_row(0, 1, 7, 16'h0004, 32'h0, 32'h0, 0);
	add_row(0, 1, 8, 16'h0008, 32'h0, 32'h0, 0);
	add_row(0, 1, 9, 16'h000c, 32'h0, 32'h0, 0);
	add_row(0, 1, 10, 16'h0010, 32'h0, 32'h0, 0);
	add_row(0, 1, 11, 16'h0014, 32'h0, 32'h0, 0);
	add_row(0, 1, 12, 16'h0018, 32'h0, 32'h0, 0);
	add_row(0, 1, 13, 16'h001c, 32'h0, 32'h0, 0);
	// word 0 is the read-only ID
	add_row(0, 1, -1, 16'h4000, 32'h0, ID_0, 0);
	add_row(0, 1, -1, 16'h0000, 32'h0, ID_1, 0);
	add_row(1, 0, -1, 16'h4000, 32'hffff_ffff, 32'h0, 1);
	add_row(1, 0, -1, 16'h0000, 32'hffff_ffff, 32'h0, 1);
	add_row(0, 1, -1, 16'h4000, 32'h0, ID_0, 0);
	add_row(0, 1, -1, 16'h0000, 32'h0, ID_1, 0);
	// unmapped space errors out and leaves word 4 of both slaves alone
	add_row(1, 1, -1, 16'h8000, 32'ha5a5_a5a5, 32'h0, 1);
	add_row(0, 1, -1, 16'h8000, 32'h0, 32'h0, 1);
	add_row(1, 1, -1, 16'hc010, 32'h1234_5678, 32'h0, 1);
	add_row(0, 1, -1, 16'hc010, 32'h0, 32'h0, 1);
	add_row(0, 1, 3, 16'h4010, 32'h0, 32'h0, 0);
	add_row(0, 1, 10, 16'h0010, 32'h0, 32'h0, 0);
	// same offset in both slaves
	add_row(1, 0, 14, 16'h4018, 32'h0, 32'h0, 0);
	add_row(1, 0, 15, 16'h0018, 32'h0, 32'h0, 0);
	add_row(0, 1, 14, 16'h4018, 32'h0, 32'h0, 0);
	add_row(0, 1, 15, 16'h0018, 32'h0, 32'h0, 0);
endtask

`endif

//--- tests/tb_apb_subsys.sv
`timescale 1ns/100ps

module tb_apb_subsys;

localparam int CLK_PERIOD     = 20;
localparam int RESET_CYCLES   = 8;
localparam int CYCLES_PER_ROW = 20;
localparam logic [31:0] ID_0  = 32'h5ec0_0000;
localparam logic [31:0] ID_1  = 32'h5ec0_0001;

typedef struct {
	bit          wr;
	bit          chk_rd;
	int          slot; // index into pool, -1 takes the literal columns
	logic [15:0] addr;
	logic [31:0] wdata;
	logic [31:0] exp_rdata;
	bit          exp_err;
} row_t;

logic        clk;
logic        rst_n;
logic        cmd_req;
logic        cmd_write;
logic [15:0] cmd_addr;
logic [31:0] cmd_wdata;
logic        cmd_ack;
logic [31:0] cmd_rdata;
logic        cmd_err;

row_t        rows[$];
logic [31:0] pool [16]; // random write data, read back by later rows
int          seed = 51906;
int          n_pass = 0;
int          n_fail = 0;
bit          table_ready = 0;

`include "tb_apb_vectors.svh"

apb_subsys_top #(
	.WAIT_STATES_0(0),
	.WAIT_STATES_1(3),
	.ID_WORD_0(ID_0),
	.ID_WORD_1(ID_1)
) dut_i (
	.clk(clk),
	.rst_n(rst_n),
	.cmd_req(cmd_req),
	.cmd_write(cmd_write),
	.cmd_addr(cmd_addr),
	.cmd_wdata(cmd_wdata),
	.cmd_ack(cmd_ack),
	.cmd_rdata(cmd_rdata),
	.cmd_err(cmd_err)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp, inout bit ok);
	assert (got === exp) else begin
		$display("[FAIL] %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		ok = 0;
	end
endtask

// one full four-phase command, response taken while ack is high
task automatic run_row(input row_t r, output bit ok);
	logic [31:0] wdata;
	logic [31:0] exp_rdata;
	logic [31:0] got_rdata;
	logic        got_err;
	ok = 1;
	wdata     = (r.slot >= 0) ? pool[r.slot] : r.wdata;
	exp_rdata = (r.slot >= 0) ? pool[r.slot] : r.exp_rdata;
	@(posedge clk);
	cmd_write <= r.wr;
	cmd_addr  <= r.addr;
	cmd_wdata <= wdata;
	cmd_req   <= 1'b1;
	@(posedge clk);
	while (!cmd_ack) @(posedge clk); // slow slaves stretch this
	got_rdata = cmd_rdata;
	got_err   = cmd_err;
	cmd_req <= 1'b0;
	@(posedge clk);
	while (cmd_ack) @(posedge clk);
	check_value("cmd_err", {31'b0, got_err}, {31'b0, r.exp_err}, ok);
	if (r.chk_rd)
		check_value("cmd_rdata", got_rdata, exp_rdata, ok);
endtask

initial begin
	bit ok;
	rst_n     = 1'b0;
	cmd_req   = 1'b0;
	cmd_write = 1'b0;
	cmd_addr  = '0;
	cmd_wdata = '0;
	for (int i = 0; i < 16; i++) begin
		pool[i] = $random(seed);
	end
	fill_table();
	table_ready = 1;

	repeat (RESET_CYCLES) @(posedge clk);
	rst_n <= 1'b1;
	@(posedge clk);
	ok = 1;
	check_value("cmd_ack", {31'b0, cmd_ack}, 32'h0, ok);
	$display("reset check: %s", ok ? "ok" : "FAILED");
	if (ok)
		n_pass++;
	else
		n_fail++;

	for (int i = 0; i < rows.size(); i++) begin
		run_row(rows[i], ok);
		$display("row %0d %s 0x%h: %s", i, rows[i].wr ? "write" : "read ", rows[i].addr,
			ok ? "ok" : "FAILED");
		if (ok)
			n_pass++;
		else
			n_fail++;
	end

	$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
	if (n_fail == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

initial begin
	wait (table_ready);
	repeat (RESET_CYCLES + rows.size() * CYCLES_PER_ROW) @(posedge clk);
	$display("timeout: a command handshake did not finish in time");
	$display("Simulation failed");
	$finish;
end

endmodule
